//--- Makefile
TOP = tb_mem_stage

.PHONY: all lint clean

all:
	verilator --binary --timing --top-module $(TOP) -f sim.f -o sim
	out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir

//--- data_access.sv
`timescale 1ns/1ps
`default_nettype none

module data_access (
	input  logic                             clk,
	input  logic                             rst_n,
	// from execute
	input  logic                             cmd_ld_ma,
	input  logic                             cmd_st_ma,
	input  logic                             wbk_rd_reg_ma,
	input  logic [4:0]                       rd_adr_ma,
	input  logic [mem_stage_pkg::DATA_W-1:0] rd_data_ma,
	input  logic [mem_stage_pkg::DATA_W-1:0] st_data_ma,
	input  logic [2:0]                       ldst_code_ma,
	input  logic                             cpu_stat_dmrw,
	// to register write-back
	output logic [4:0]                       rd_adr_wb,
	output logic                             wbk_rd_reg_wb,
	output logic [mem_stage_pkg::DATA_W-1:0] wbk_data_wb,
	output logic                             dmrw_run,
	data_mem_if.initiator                    mem,
	io_bus_if.initiator                      io
);

	localparam logic [2:0] ST_IDLE = 3'b000;
	localparam logic [2:0] ST_READ = 3'b001;
	localparam logic [2:0] ST_WRTE = 3'b010;
	localparam logic [2:0] ST_IOR1 = 3'b101;
	localparam logic [2:0] ST_IOR2 = 3'b111;
	localparam logic [2:0] ST_IOWT = 3'b110;

	mem_stage_pkg::data_addr_u        ex_adr;
	logic                             sel_io;
	logic                             sel_mem;
	logic                             ld_mem_req;
	logic                             st_mem_req;
	logic                             size_w;
	logic                             size_hw;
	logic [2:0]                       state;
	logic [2:0]                       next_state;
	logic                             acc_done;
	logic                             req_w_dly;
	logic                             req_hw_dly;
	logic                             io_ren_dly;
	logic [mem_stage_pkg::DATA_W-1:0] ext_rdata;
	logic                             io_wb;
	logic                             mem_wb;
	logic                             alu_wb;

	// region decode on the execute result
	assign ex_adr     = rd_data_ma;
	assign sel_io     = (ex_adr.io.region == mem_stage_pkg::IO_REGION);
	assign sel_mem    = ~sel_io;
	assign ld_mem_req = cmd_ld_ma & sel_mem;
	assign st_mem_req = cmd_st_ma & sel_mem;
	assign size_w     = (ldst_code_ma == mem_stage_pkg::LDST_W);
	assign size_hw    = (ldst_code_ma == mem_stage_pkg::LDST_H);

	// requests drop once the access is done, so the controller can rearm
	assign mem.read_req  = ld_mem_req & ~acc_done;
	assign mem.write_req = st_mem_req & ~acc_done;
	assign mem.req_w     = size_w & sel_mem;
	assign mem.req_hw    = size_hw & sel_mem;
	assign mem.adr       = ex_adr.mem_adr;
	assign mem.wdata     = st_data_ma;

	// only word stores reach the IO block
	assign io.we      = cmd_st_ma & sel_io & size_w;
	assign io.wadr    = ex_adr.io.word_idx;
	assign io.wdata   = st_data_ma;
	assign io.radr    = ex_adr.io.word_idx;
	assign io.radr_en = cmd_ld_ma & sel_io;

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE: begin
				if (acc_done)
					next_state = ST_IDLE;
				else if (ld_mem_req)
					next_state = ST_READ;
				else if (st_mem_req)
					next_state = ST_WRTE;
				else if (io.radr_en)
					next_state = ST_IOR1;
				else if (io.we)
					next_state = ST_IOWT;
			end
			ST_READ: begin
				if (mem.read_valid)
					next_state = ST_IDLE;
			end
			ST_WRTE: begin
				if (mem.write_finish)
					next_state = ST_IDLE;
			end
			ST_IOR1: next_state = ST_IOR2;
			ST_IOR2: next_state = ST_IDLE;
			ST_IOWT: next_state = ST_IDLE;
			default: next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	assign dmrw_run = (state != ST_IDLE) | (next_state != ST_IDLE);

	// keeps a finished command that is still held from starting again
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			acc_done <= 1'b0;
		else if ((state != ST_IDLE) && (next_state == ST_IDLE))
			acc_done <= 1'b1;
		else if (!dmrw_run)
			acc_done <= 1'b0;
	end

	// load size and IO read enable, one cycle behind
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_w_dly  <= 1'b0;
			req_hw_dly <= 1'b0;
			io_ren_dly <= 1'b0;
		end else begin
			io_ren_dly <= io.radr_en;
			if (ld_mem_req) begin
				req_w_dly  <= size_w;
				req_hw_dly <= size_hw;
			end
		end
	end

	// sign extension of the low bytes
	assign ext_rdata = req_w_dly  ? mem.rdata :
	                   req_hw_dly ? {{16{mem.rdata[15]}}, mem.rdata[15:0]} :
	                                {{24{mem.rdata[7]}}, mem.rdata[7:0]};

	assign io_wb  = io_ren_dly & ((state == ST_IOR1) | (state == ST_IOR2));
	assign mem_wb = mem.read_valid & (state == ST_READ);
	// plain ALU result, no memory access involved
	assign alu_wb = wbk_rd_reg_ma & cpu_stat_dmrw & ~cmd_ld_ma & ~cmd_st_ma &
	                (next_state == ST_IDLE);

	assign wbk_data_wb   = io_wb  ? io.rdata :
	                       mem_wb ? ext_rdata : rd_data_ma;
	assign wbk_rd_reg_wb = io_wb | mem_wb | alu_wb;
	assign rd_adr_wb     = rd_adr_ma;

endmodule

`default_nettype wire

//--- data_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem_ctrl #(
	parameter int MEM_WORDS   = 1024,
	parameter int MEM_LATENCY = 3
) (
	input  logic      clk,
	input  logic      rst_n,
	data_mem_if.target bus
);

	localparam int AW = $clog2(MEM_WORDS);
	localparam int CW = $clog2(MEM_LATENCY + 1);

	logic [mem_stage_pkg::DATA_W-1:0] mem_array [MEM_WORDS];
	logic                             busy;
	logic                             hold;
	logic [CW-1:0]                    cnt;
	logic                             any_req;
	logic                             fire;
	logic [AW-1:0]                    widx;
	logic [1:0]                       off;
	logic [2:0]                       acc_size;
	logic [3:0]                       wmask;
	logic [mem_stage_pkg::DATA_W-1:0] wdata_sh;

	assign any_req = bus.read_req | bus.write_req;
	// last cycle of the latency window
	assign fire    = busy & (cnt <= 1);

	assign widx = bus.adr[AW+1:2];
	assign off  = bus.adr[1:0];

	assign acc_size = bus.req_w  ? mem_stage_pkg::LDST_W :
	                  bus.req_hw ? mem_stage_pkg::LDST_H : mem_stage_pkg::LDST_B;

	always_comb begin
		case (acc_size)
			mem_stage_pkg::LDST_W: wmask = 4'b1111 << off;
			mem_stage_pkg::LDST_H: wmask = 4'b0011 << off;
			default:               wmask = 4'b0001 << off;
		endcase
	end

	assign wdata_sh = bus.wdata << {off, 3'b000};

	// latency counter and response pulses
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy             <= 1'b0;
			hold             <= 1'b0;
			cnt              <= '0;
			bus.read_valid   <= 1'b0;
			bus.write_finish <= 1'b0;
		end else begin
			bus.read_valid   <= 1'b0;
			bus.write_finish <= 1'b0;
			if (hold) begin
				// wait for the stage to drop the request
				if (!any_req)
					hold <= 1'b0;
			end else if (busy) begin
				if (fire) begin
					busy             <= 1'b0;
					hold             <= 1'b1;
					bus.read_valid   <= bus.read_req;
					bus.write_finish <= bus.write_req & ~bus.read_req;
				end else begin
					cnt <= cnt - 1'b1;
				end
			end else if (any_req) begin
				busy <= 1'b1;
				cnt  <= CW'(MEM_LATENCY - 1);
			end
		end
	end

	// byte lane writes into the word array
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem_array[i] <= '0;
		end else if (fire && bus.write_req && !bus.read_req) begin
			for (int b = 0; b < 4; b++)
				if (wmask[b])
					mem_array[widx][8*b +: 8] <= wdata_sh[8*b +: 8];
		end
	end

	// read data comes back aligned to bit 0
	always_ff @(posedge clk) begin
		if (fire && bus.read_req)
			bus.rdata <= mem_array[widx] >> {off, 3'b000};
	end

endmodule

`default_nettype wire

//--- data_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface data_mem_if;

	// request side, held as levels by the stage
	logic                            read_req;
	logic                            write_req;
	logic                            req_w;
	logic                            req_hw;
	logic [mem_stage_pkg::DATA_W-1:0] adr;
	logic [mem_stage_pkg::DATA_W-1:0] wdata;

	// one cycle answers from the controller
	logic                            read_valid;
	logic [mem_stage_pkg::DATA_W-1:0] rdata;
	logic                            write_finish;

	modport initiator (
		output read_req, write_req, req_w, req_hw, adr, wdata,
		input  read_valid, rdata, write_finish
	);

	modport target (
		input  read_req, write_req, req_w, req_hw, adr, wdata,
		output read_valid, rdata, write_finish
	);

endinterface

`default_nettype wire

//--- io_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface io_bus_if;

	// word index fields, byte offset already stripped
	logic                            we;
	logic [13:0]                     wadr;
	logic [mem_stage_pkg::DATA_W-1:0] wdata;
	logic [13:0]                     radr;
	logic                            radr_en;
	logic [mem_stage_pkg::DATA_W-1:0] rdata;

	modport initiator (
		output we, wadr, wdata, radr, radr_en,
		input  rdata
	);

	modport target (
		input  we, wadr, wdata, radr, radr_en,
		output rdata
	);

endinterface

`default_nettype wire

//--- io_regs.sv
`timescale 1ns/1ps
`default_nettype none

module io_regs #(
	parameter int IO_WORDS = 64
) (
	input  logic    clk,
	input  logic    rst_n,
	io_bus_if.target bus
);

	localparam int IW = $clog2(IO_WORDS);

	logic [mem_stage_pkg::DATA_W-1:0] regs [IO_WORDS];
	logic [IW-1:0]                    widx;
	logic [IW-1:0]                    ridx;

	// low bits of the word index pick the register
	assign widx = bus.wadr[IW-1:0];
	assign ridx = bus.radr[IW-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < IO_WORDS; i++)
				regs[i] <= '0;
		end else if (bus.we) begin
			regs[widx] <= bus.wdata;
		end
	end

	// registered read port, refreshed while radr_en is held
	always_ff @(posedge clk) begin
		if (bus.radr_en)
			bus.rdata <= regs[ridx];
	end

endmodule

`default_nettype wire

//--- mem_stage_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_checker (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        wbk_rd_reg_wb,
	input  logic [4:0]  rd_adr_wb,
	input  logic [31:0] wbk_data_wb,
	input  logic        dmrw_run,
	// expectation for the command currently held
	input  logic        exp_wb,
	input  logic [4:0]  exp_adr,
	input  logic [31:0] exp_data,
	output int          errors,
	output int          checked
);

	int seen;

	task automatic compare_value(
		input string       name,
		input logic [31:0] exp_val,
		input logic [31:0] act_val
	);
		if (act_val !== exp_val) begin
			$display("FAILED at %0t: %s expected 0x%08h, got 0x%08h",
				$time, name, exp_val, act_val);
			errors++;
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			errors  = 0;
			checked = 0;
			seen    = 0;
		end else begin
			if (wbk_rd_reg_wb) begin
				if (!exp_wb) begin
					$display("unexpected write-back to register %0d at %0t",
						rd_adr_wb, $time);
					errors++;
				end else begin
					compare_value("rd_adr_wb", {27'd0, exp_adr}, {27'd0, rd_adr_wb});
					compare_value("wbk_data_wb", exp_data, wbk_data_wb);
					checked++;
					seen++;
				end
			end
			// a command ends at the first edge with dmrw_run low
			if (!dmrw_run) begin
				if (exp_wb && seen == 0) begin
					$display("no write-back for register %0d, command ended at %0t",
						exp_adr, $time);
					errors++;
				end
				seen = 0;
			end
		end
	end

endmodule

`default_nettype wire

//--- mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

	// data path and byte address width
	localparam int DATA_W = 32;

	// size field of ldst_code, any code not listed acts as a byte
	localparam logic [2:0] LDST_B = 3'b000;
	localparam logic [2:0] LDST_H = 3'b001;
	localparam logic [2:0] LDST_W = 3'b010;

	// address bits 31:30 that select the IO register block
	localparam logic [1:0] IO_REGION = 2'b11;

	// address as seen by the IO block
	typedef struct packed {
		logic [1:0]  region;
		logic [13:0] unused;
		logic [13:0] word_idx;
		logic [1:0]  byte_off;
	} io_addr_t;

	// execute result word, read as memory byte address or as IO address
	typedef union packed {
		logic [DATA_W-1:0] mem_adr;
		io_addr_t          io;
	} data_addr_u;

endpackage

`default_nettype wire

//--- mem_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top #(
	parameter int MEM_WORDS   = 1024,
	parameter int MEM_LATENCY = 3,
	parameter int IO_WORDS    = 64
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             cmd_ld,
	input  logic                             cmd_st,
	input  logic                             wbk_rd_reg,
	input  logic [4:0]                       rd_adr,
	input  logic [mem_stage_pkg::DATA_W-1:0] rd_data,
	input  logic [mem_stage_pkg::DATA_W-1:0] st_data,
	input  logic [2:0]                       ldst_code,
	input  logic                             cpu_stat_dmrw,
	output logic [4:0]                       rd_adr_wb,
	output logic                             wbk_rd_reg_wb,
	output logic [mem_stage_pkg::DATA_W-1:0] wbk_data_wb,
	output logic                             dmrw_run
);

	data_mem_if mem_bus ();
	io_bus_if   io_bus ();

	data_access u_data_access (
		.clk           (clk),
		.rst_n         (rst_n),
		.cmd_ld_ma     (cmd_ld),
		.cmd_st_ma     (cmd_st),
		.wbk_rd_reg_ma (wbk_rd_reg),
		.rd_adr_ma     (rd_adr),
		.rd_data_ma    (rd_data),
		.st_data_ma    (st_data),
		.ldst_code_ma  (ldst_code),
		.cpu_stat_dmrw (cpu_stat_dmrw),
		.rd_adr_wb     (rd_adr_wb),
		.wbk_rd_reg_wb (wbk_rd_reg_wb),
		.wbk_data_wb   (wbk_data_wb),
		.dmrw_run      (dmrw_run),
		.mem           (mem_bus.initiator),
		.io            (io_bus.initiator)
	);

	data_mem_ctrl #(
		.MEM_WORDS   (MEM_WORDS),
		.MEM_LATENCY (MEM_LATENCY)
	) u_data_mem_ctrl (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (mem_bus.target)
	);

	io_regs #(
		.IO_WORDS (IO_WORDS)
	) u_io_regs (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (io_bus.target)
	);

endmodule

`default_nettype wire

//--- sim.f
mem_stage_pkg.sv
data_mem_if.sv
io_bus_if.sv
data_access.sv
data_mem_ctrl.sv
io_regs.sv
mem_stage_top.sv
mem_stage_checker.sv
tb_mem_stage.sv

//--- tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

	localparam int MEM_WORDS = 256;
	localparam int IO_WORDS  = 64;
	localparam int N_OPS     = 300;
	localparam int TIMEOUT   = 50;

	logic        clk;
	logic        rst_n;
	logic        cmd_ld;
	logic        cmd_st;
	logic        wbk_rd_reg;
	logic [4:0]  rd_adr;
	logic [31:0] rd_data;
	logic [31:0] st_data;
	logic [2:0]  ldst_code;
	logic        cpu_stat_dmrw;
	logic [4:0]  rd_adr_wb;
	logic        wbk_rd_reg_wb;
	logic [31:0] wbk_data_wb;
	logic        dmrw_run;
	logic        exp_wb;
	logic [4:0]  exp_adr;
	logic [31:0] exp_data;
	int          errors;
	int          checked;
	int          timeouts;

	logic [31:0] lfsr;
	logic [7:0]  mem_model [MEM_WORDS*4];
	logic [31:0] io_model [IO_WORDS];
	logic [9:0]  last_mem_adr;
	logic [5:0]  last_io_idx;

	mem_stage_top #(
		.MEM_WORDS   (MEM_WORDS),
		.MEM_LATENCY (3),
		.IO_WORDS    (IO_WORDS)
	) uut (.*);

	mem_stage_checker chk (.*);

	always #5 clk = ~clk;

	// right shifting Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
	endtask

	// unlisted codes act as a byte
	function automatic int size_bytes(input logic [2:0] code);
		if (code == mem_stage_pkg::LDST_W)
			return 4;
		if (code == mem_stage_pkg::LDST_H)
			return 2;
		return 1;
	endfunction

	function automatic logic [31:0] load_model(input logic [9:0] a, input int n);
		if (n == 4)
			return {mem_model[a+3], mem_model[a+2], mem_model[a+1], mem_model[a]};
		if (n == 2)
			return {{16{mem_model[a+1][7]}}, mem_model[a+1], mem_model[a]};
		return {{24{mem_model[a][7]}}, mem_model[a]};
	endfunction

	task automatic run_op();
		logic [31:0] r;
		logic [2:0]  kind;
		logic [2:0]  code;
		logic [4:0]  reg_adr;
		logic [31:0] sdata;
		logic        reuse;
		logic [9:0]  adr;
		logic [5:0]  idx;
		int          n;
		int          cycles;
		logic        done;

		take_bits(3, r);
		kind = r[2:0];
		take_bits(3, r);
		code = r[2:0];
		take_bits(5, r);
		reg_adr = r[4:0];
		take_bits(32, r);
		sdata = r;
		take_bits(1, r);
		reuse = r[0];
		take_bits(10, r);
		adr = reuse ? last_mem_adr : r[9:0];
		take_bits(6, r);
		idx = reuse ? last_io_idx : r[5:0];
		n = size_bytes(code);
		// natural alignment for the access size
		adr = adr & ~10'(n - 1);

		#1;
		cmd_ld        = 1'b0;
		cmd_st        = 1'b0;
		wbk_rd_reg    = 1'b0;
		cpu_stat_dmrw = 1'b1;
		rd_adr        = reg_adr;
		st_data       = sdata;
		ldst_code     = code;
		exp_wb        = 1'b0;
		exp_adr       = reg_adr;
		exp_data      = '0;
		case (kind)
			3'd0, 3'd1: begin
				cmd_st  = 1'b1;
				rd_data = {22'd0, adr};
				for (int i = 0; i < n; i++)
					mem_model[adr + i] = sdata[8*i +: 8];
				last_mem_adr = adr;
			end
			3'd2, 3'd3: begin
				cmd_ld     = 1'b1;
				wbk_rd_reg = 1'b1;
				rd_data    = {22'd0, adr};
				exp_wb     = 1'b1;
				exp_data   = load_model(adr, n);
			end
			3'd4: begin
				// non-word stores to IO are dropped
				cmd_st  = 1'b1;
				rd_data = {mem_stage_pkg::IO_REGION, 14'd0, 8'd0, idx, 2'b00};
				if (code == mem_stage_pkg::LDST_W)
					io_model[idx] = sdata;
				last_io_idx = idx;
			end
			3'd5: begin
				cmd_ld     = 1'b1;
				wbk_rd_reg = 1'b1;
				ldst_code  = mem_stage_pkg::LDST_W;
				rd_data    = {mem_stage_pkg::IO_REGION, 14'd0, 8'd0, idx, 2'b00};
				exp_wb     = 1'b1;
				exp_data   = io_model[idx];
			end
			default: begin
				// outside the data access state nothing is written back
				wbk_rd_reg    = 1'b1;
				cpu_stat_dmrw = kind[0];
				rd_data       = sdata;
				exp_wb        = kind[0];
				exp_data      = sdata;
			end
		endcase

		// hold the command until dmrw_run is seen low at an edge
		cycles = 0;
		done   = 1'b0;
		while (!done && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
			done = !dmrw_run;
		end
		if (!done) begin
			$display("timeout: dmrw_run still high %0d cycles into op kind %0d at %0t",
				TIMEOUT, kind, $time);
			timeouts++;
		end
	endtask

	initial begin
		lfsr          = 32'd76053;
		clk           = 1'b0;
		rst_n         = 1'b0;
		cmd_ld        = 1'b0;
		cmd_st        = 1'b0;
		wbk_rd_reg    = 1'b0;
		rd_adr        = '0;
		rd_data       = '0;
		st_data       = '0;
		ldst_code     = '0;
		cpu_stat_dmrw = 1'b0;
		exp_wb        = 1'b0;
		exp_adr       = '0;
		exp_data      = '0;
		timeouts      = 0;
		last_mem_adr  = '0;
		last_io_idx   = '0;
		for (int i = 0; i < MEM_WORDS*4; i++)
			mem_model[i] = '0;
		for (int i = 0; i < IO_WORDS; i++)
			io_model[i] = '0;

		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		for (int k = 0; k < N_OPS && timeouts == 0; k++)
			run_op();

		#1;
		cmd_ld        = 1'b0;
		cmd_st        = 1'b0;
		wbk_rd_reg    = 1'b0;
		cpu_stat_dmrw = 1'b0;
		exp_wb        = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		$display("write-backs checked: %0d, errors: %0d, timeouts: %0d",
			checked, errors, timeouts);
		if (errors == 0 && timeouts == 0 && checked > 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
